//--- logic/bk_bus_pkg.sv
// bk memory bus subsystem shared definitions
// request structs for the cpu, debug host and memory sides,
// slot owner and sequencer state enums, default sizes
`default_nettype none

package bk_bus_pkg;

    // ====================
    // default sizes
    localparam int mem_words_default   = 4096;   // words in the video ram
    localparam int video_base_default  = 2048;   // first word of the video window
    localparam int video_words_default = 64;     // window length, fetch pointer wraps here

    // ====================
    // cpu bus request, 36 bits
    typedef struct packed {
        logic        rd;        // read cycle
        logic        wt;        // write cycle
        logic        byte_op;   // byte access, lane picked by addr[0]
        logic        ifetch;    // instruction fetch, checked by the breakpoint
        logic [15:0] addr;      // byte address
        logic [15:0] wdata;
    } cpu_bus_t;

    // host commands
    typedef enum logic [1:0] {
        host_read       = 2'd0,
        host_write      = 2'd1,
        host_set_bkpt   = 2'd2,
        host_clear_bkpt = 2'd3
    } host_op_e;

    // debug host request, 34 bits
    typedef struct packed {
        host_op_e    op;
        logic [15:0] addr;      // word address, or the breakpoint byte address
        logic [15:0] wdata;
    } host_cmd_t;

    // one memory access, 35 bits
    typedef struct packed {
        logic        we;
        logic [1:0]  lane_en;   // bit 1 high byte, bit 0 low byte
        logic [15:0] addr;      // word address
        logic [15:0] wdata;
    } mem_req_t;

    // owner of the current clock on the slot wheel
    typedef enum logic [1:0] {
        slot_idle  = 2'd0,
        slot_video = 2'd1,
        slot_cpu   = 2'd2,
        slot_host  = 2'd3
    } slot_e;

    // cpu cycle sequencer
    typedef enum logic [1:0] {
        seq_idle   = 2'd0,     // waiting for rd/wt and a cpu slot
        seq_access = 2'd1,     // memory accessed, read data arriving
        seq_reply  = 2'd2      // reply up until the cpu drops rd/wt
    } seq_state_e;

endpackage

`default_nettype wire

//--- logic/slot_timer.sv
// slot wheel
// free running 16 phase counter, decoded into the owner of each clock:
// phase 1 video, phases 3/7/11/15 cpu, phases 5/13 host, rest idle
`timescale 1ns/1ps
`default_nettype none

module slot_timer (
    input  logic              clk25,
    input  logic              reset_in,
    output bk_bus_pkg::slot_e slot,
    output logic [3:0]        phase
);

    // ====================
    // phase counter
    always_ff @(posedge clk25) begin
        if (reset_in) begin
            phase <= 4'd0;
        end else begin
            phase <= phase + 4'd1;     // wraps 15 -> 0
        end
    end

    // ====================
    // ownership table
    always_comb begin
        if (phase == 4'd1) begin
            slot = bk_bus_pkg::slot_video;             // one fetch per 16 pixels
        end else if (phase[1:0] == 2'b11) begin
            slot = bk_bus_pkg::slot_cpu;               // 3, 7, 11, 15
        end else if (phase[2:0] == 3'b101) begin
            slot = bk_bus_pkg::slot_host;              // 5, 13
        end else begin
            slot = bk_bus_pkg::slot_idle;
        end
    end

endmodule

`default_nettype wire

//--- logic/host_port.sv
// debug host port
// four phase req/ack handshake; reads and writes wait for a host slot,
// breakpoint commands pulse set/clear toward the cpu sequencer.
// ack stays up until req is dropped
`timescale 1ns/1ps
`default_nettype none

module host_port (
    input  logic                  clk25,
    input  logic                  reset_in,
    input  logic                  host_req,
    input  bk_bus_pkg::host_cmd_t host_cmd,
    output logic                  host_ack,
    output logic [15:0]           host_rdata,
    input  bk_bus_pkg::slot_e     slot,
    input  logic [15:0]           mem_rdata,
    output bk_bus_pkg::mem_req_t  host_mem,
    output logic                  host_active,
    output logic                  bkpt_set,
    output logic                  bkpt_clear,
    output logic [15:0]           bkpt_addr_in
);

    typedef enum logic [1:0] {
        hp_idle = 2'd0,     // no request, ack low
        hp_wait = 2'd1,     // memory command waiting for its slot
        hp_exec = 2'd2,     // read data back, or breakpoint pulse
        hp_ack  = 2'd3      // ack up until req drops
    } hp_state_e;

    hp_state_e state;
    logic      is_mem_op;   // read or write, needs a memory slot

    assign is_mem_op = (host_cmd.op == bk_bus_pkg::host_read) |
                       (host_cmd.op == bk_bus_pkg::host_write);

    // access right away if the request lands in a host slot
    assign host_active = is_mem_op & (slot == bk_bus_pkg::slot_host) &
                         (((state == hp_idle) & host_req) | (state == hp_wait));

    // ====================
    // handshake fsm
    always_ff @(posedge clk25) begin
        if (reset_in) begin
            state <= hp_idle;
        end else begin
            case (state)
                hp_idle: begin
                    if (host_req) begin
                        if (!is_mem_op || host_active)
                            state <= hp_exec;   // bkpt cmd, or slot already here
                        else
                            state <= hp_wait;
                    end
                end
                hp_wait: if (host_active) state <= hp_exec;
                hp_exec: state <= hp_ack;
                hp_ack:  if (!host_req) state <= hp_idle;   // ack falls here
                default: state <= hp_idle;
            endcase
        end
    end

    // read data shows up the clock after the access
    always_ff @(posedge clk25) begin
        if ((state == hp_exec) && (host_cmd.op == bk_bus_pkg::host_read))
            host_rdata <= mem_rdata;
    end

    assign host_ack = (state == hp_ack);

    // breakpoint pulses, one clock long
    assign bkpt_set     = (state == hp_exec) & (host_cmd.op == bk_bus_pkg::host_set_bkpt);
    assign bkpt_clear   = (state == hp_exec) & (host_cmd.op == bk_bus_pkg::host_clear_bkpt);
    assign bkpt_addr_in = host_cmd.addr;    // cmd held stable while req is up

    // full word access; top only passes it on while host_active
    assign host_mem.we      = (host_cmd.op == bk_bus_pkg::host_write);
    assign host_mem.lane_en = 2'b11;
    assign host_mem.addr    = host_cmd.addr;
    assign host_mem.wdata   = host_cmd.wdata;

endmodule

`default_nettype wire

//--- logic/bus_sequencer.sv
// cpu bus cycle sequencer
// runs each rd/wt cycle in the next cpu slot and answers with cpu_reply,
// maps byte addresses onto word address and byte lanes,
// and holds the instruction fetch breakpoint with its stall latch
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer (
    input  logic                 clk25,
    input  logic                 reset_in,
    input  bk_bus_pkg::cpu_bus_t cpu_bus,
    output logic                 cpu_reply,
    output logic [15:0]          cpu_rdata,
    input  bk_bus_pkg::slot_e    slot,
    input  logic [15:0]          mem_rdata,
    output bk_bus_pkg::mem_req_t cpu_mem,
    output logic                 cpu_active,
    input  logic                 bkpt_set,
    input  logic                 bkpt_clear,
    input  logic [15:0]          bkpt_addr_in,
    output logic                 bkpt_hit
);

    bk_bus_pkg::seq_state_e state;
    logic        cycle_req;     // rd or wt up
    logic        fetch_match;   // armed and this is the breakpoint fetch
    logic        bkpt_armed;
    logic [15:0] bkpt_addr;
    logic        stall;

    assign cycle_req   = cpu_bus.rd | cpu_bus.wt;
    assign fetch_match = bkpt_armed & cpu_bus.rd & cpu_bus.ifetch &
                         (cpu_bus.addr == bkpt_addr);

    // access happens in this clock; a stalled fetch never reaches memory
    assign cpu_active = (state == bk_bus_pkg::seq_idle) & cycle_req & ~stall &
                        ~fetch_match & (slot == bk_bus_pkg::slot_cpu);

    // ====================
    // byte address to word address and lanes
    always_comb begin
        cpu_mem.we   = cpu_bus.wt;                    // gated by cpu_active at the top
        cpu_mem.addr = {1'b0, cpu_bus.addr[15:1]};
        if (cpu_bus.byte_op) begin
            cpu_mem.lane_en = cpu_bus.addr[0] ? 2'b10 : 2'b01;   // odd addr -> high byte
            cpu_mem.wdata   = {2{cpu_bus.wdata[7:0]}};         // low byte on both lanes
        end else begin
            cpu_mem.lane_en = 2'b11;
            cpu_mem.wdata   = cpu_bus.wdata;
        end
    end

    // ====================
    // cycle fsm and breakpoint
    always_ff @(posedge clk25) begin
        if (reset_in) begin
            state      <= bk_bus_pkg::seq_idle;
            bkpt_armed <= 1'b0;
            stall      <= 1'b0;
        end else begin
            case (state)
                bk_bus_pkg::seq_idle:   if (cpu_active) state <= bk_bus_pkg::seq_access;
                bk_bus_pkg::seq_access: state <= bk_bus_pkg::seq_reply;
                bk_bus_pkg::seq_reply: begin
                    if (!cycle_req)
                        state <= bk_bus_pkg::seq_idle;   // reply drops one clock after rd/wt
                end
                default: state <= bk_bus_pkg::seq_idle;
            endcase

            // clear wins over a hit in the same clock, held fetch then goes on
            if (bkpt_clear) begin
                bkpt_armed <= 1'b0;
                stall      <= 1'b0;
            end else begin
                if (bkpt_set)
                    bkpt_armed <= 1'b1;
                if ((state == bk_bus_pkg::seq_idle) && fetch_match)
                    stall <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk25) begin
        if (bkpt_set)
            bkpt_addr <= bkpt_addr_in;               // byte address of the fetch
        if (state == bk_bus_pkg::seq_access)
            cpu_rdata <= mem_rdata;                  // whole word, also for byte reads
    end

    assign cpu_reply = (state == bk_bus_pkg::seq_reply);
    assign bkpt_hit  = stall;

endmodule

`default_nettype wire

//--- logic/video_ram.sv
// video ram
// word array shared by all bus users, byte lane write enables,
// registered read of the addressed word every clock
`timescale 1ns/1ps
`default_nettype none

module video_ram #(
    parameter int mem_words = bk_bus_pkg::mem_words_default
) (
    input  logic                 clk25,
    input  bk_bus_pkg::mem_req_t mem,
    output logic [15:0]          rdata
);

    localparam int aw = (mem_words > 1) ? $clog2(mem_words) : 1;

    logic [15:0]   mem_array [mem_words];
    logic [aw-1:0] word_idx;

    // addresses fold back onto the array
    assign word_idx = aw'(32'(mem.addr) % mem_words);

    // ====================
    // contents start cleared
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem_array[i] = 16'h0000;
        end
    end

    // ====================
    // write lanes
    always_ff @(posedge clk25) begin
        if (mem.we) begin
            if (mem.lane_en[0])
                mem_array[word_idx][7:0] <= mem.wdata[7:0];     // low byte
            if (mem.lane_en[1])
                mem_array[word_idx][15:8] <= mem.wdata[15:8];   // high byte
        end
    end

    // read returns the old word on a write clock
    always_ff @(posedge clk25) begin
        rdata <= mem_array[word_idx];
    end

endmodule

`default_nettype wire

//--- logic/pixel_shifter.sv
// video fetch and pixel shifter
// steps a wrapping pointer through the video window, one fetch per video slot,
// loads the returned word and shifts it out msb first over 16 clocks
`timescale 1ns/1ps
`default_nettype none

module pixel_shifter #(
    parameter int video_base  = bk_bus_pkg::video_base_default,
    parameter int video_words = bk_bus_pkg::video_words_default
) (
    input  logic                 clk25,
    input  logic                 reset_in,
    input  bk_bus_pkg::slot_e    slot,
    input  logic [15:0]          mem_rdata,
    output bk_bus_pkg::mem_req_t video_mem,
    output logic                 video_load,
    output logic                 pixel
);

    logic [15:0] vid_offset;    // word offset inside the window
    logic [15:0] shreg;         // remaining bits, msb goes out next

    // ====================
    // fetch pointer
    always_ff @(posedge clk25) begin
        if (reset_in) begin
            vid_offset <= 16'd0;
            video_load <= 1'b0;
        end else begin
            video_load <= (slot == bk_bus_pkg::slot_video);   // word arrives next clock
            if (slot == bk_bus_pkg::slot_video) begin
                if (vid_offset == 16'(video_words - 1))
                    vid_offset <= 16'd0;                    // wrap to video_base
                else
                    vid_offset <= vid_offset + 16'd1;
            end
        end
    end

    // read only
    assign video_mem.we      = 1'b0;
    assign video_mem.lane_en = 2'b11;
    assign video_mem.addr    = 16'(video_base) + vid_offset;
    assign video_mem.wdata   = 16'h0000;

    // ====================
    // serializer
    always_ff @(posedge clk25) begin
        if (reset_in) begin
            shreg <= 16'h0000;                              // keeps pixel low
        end else if (video_load) begin
            shreg <= {mem_rdata[14:0], 1'b0};               // bit 15 already shown
        end else begin
            shreg <= {shreg[14:0], 1'b0};
        end
    end

    // bit 15 straight from ram on the load clock
    assign pixel = video_load ? mem_rdata[15] : shreg[15];

endmodule

`default_nettype wire

//--- logic/bk_membus_top.sv
// bk memory bus subsystem top
// slot wheel, cpu sequencer, debug host port and video fetch
// share one word ram; the slot owner picks the memory request
`timescale 1ns/1ps
`default_nettype none

module bk_membus_top #(
    parameter int mem_words   = bk_bus_pkg::mem_words_default,
    parameter int video_base  = bk_bus_pkg::video_base_default,
    parameter int video_words = bk_bus_pkg::video_words_default
) (
    input  logic                  clk25,
    input  logic                  reset_in,
    input  bk_bus_pkg::cpu_bus_t  cpu_bus,
    output logic                  cpu_reply,
    output logic [15:0]           cpu_rdata,
    input  logic                  host_req,
    input  bk_bus_pkg::host_cmd_t host_cmd,
    output logic                  host_ack,
    output logic [15:0]           host_rdata,
    output logic                  bkpt_hit,
    output logic                  video_load,
    output logic                  pixel
);

    bk_bus_pkg::slot_e    slot;
    bk_bus_pkg::mem_req_t cpu_mem, host_mem, video_mem;
    bk_bus_pkg::mem_req_t mem_req;      // request of the slot owner
    logic [15:0]          mem_rdata;    // to all users, one clock after the slot
    logic                 cpu_active, host_active;
    logic                 bkpt_set, bkpt_clear;
    logic [15:0]          bkpt_addr_in;

    // phase left open, it is there for probing only
    slot_timer u_slot (
        .clk25(clk25), .reset_in(reset_in), .slot(slot), .phase()
    );

    host_port u_host (
        .clk25(clk25), .reset_in(reset_in),
        .host_req(host_req), .host_cmd(host_cmd),
        .host_ack(host_ack), .host_rdata(host_rdata),
        .slot(slot), .mem_rdata(mem_rdata),
        .host_mem(host_mem), .host_active(host_active),
        .bkpt_set(bkpt_set), .bkpt_clear(bkpt_clear), .bkpt_addr_in(bkpt_addr_in)
    );

    bus_sequencer u_seq (
        .clk25(clk25), .reset_in(reset_in),
        .cpu_bus(cpu_bus), .cpu_reply(cpu_reply), .cpu_rdata(cpu_rdata),
        .slot(slot), .mem_rdata(mem_rdata),
        .cpu_mem(cpu_mem), .cpu_active(cpu_active),
        .bkpt_set(bkpt_set), .bkpt_clear(bkpt_clear), .bkpt_addr_in(bkpt_addr_in),
        .bkpt_hit(bkpt_hit)
    );

    pixel_shifter #(.video_base(video_base), .video_words(video_words)) u_pix (
        .clk25(clk25), .reset_in(reset_in), .slot(slot), .mem_rdata(mem_rdata),
        .video_mem(video_mem), .video_load(video_load), .pixel(pixel)
    );

    // ====================
    // slot mux, nothing is written unless the owner has a live access
    always_comb begin
        case (slot)
            bk_bus_pkg::slot_video: mem_req = video_mem;
            bk_bus_pkg::slot_cpu:   mem_req = cpu_active ? cpu_mem : '0;
            bk_bus_pkg::slot_host:  mem_req = host_active ? host_mem : '0;
            default:                mem_req = '0;           // idle, plain read of word 0
        endcase
    end

    video_ram #(.mem_words(mem_words)) u_ram (
        .clk25(clk25), .mem(mem_req), .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

//--- bench/tb_bk_membus.sv
// testbench for the bk memory bus subsystem
// runs the operations of the vector file on the cpu, host and video ports
// and checks them against a shadow copy of the ram
`timescale 1ns/1ps
`default_nettype none

module tb_bk_membus;

    localparam int mem_words   = 4096;
    localparam int video_base  = 2048;
    localparam int video_words = 4;       // short window, wrap shows after 4 loads
    localparam int wait_limit  = 50;      // clocks per wait
    localparam int sel_ack     = 0;
    localparam int sel_reply   = 1;
    localparam int sel_load    = 2;

    logic                  clk25;
    logic                  reset_in;
    bk_bus_pkg::cpu_bus_t  cpu_bus;
    logic                  cpu_reply;
    logic [15:0]           cpu_rdata;
    logic                  host_req;
    bk_bus_pkg::host_cmd_t host_cmd;
    logic                  host_ack;
    logic [15:0]           host_rdata;
    logic                  bkpt_hit;
    logic                  video_load;
    logic                  pixel;

    int          err_count;
    int          load_count;                  // video loads since reset
    logic [15:0] model_mem [mem_words];       // shadow of the ram contents

    bk_membus_top #(
        .mem_words(mem_words), .video_base(video_base), .video_words(video_words)
    ) uut (
        .clk25(clk25), .reset_in(reset_in),
        .cpu_bus(cpu_bus), .cpu_reply(cpu_reply), .cpu_rdata(cpu_rdata),
        .host_req(host_req), .host_cmd(host_cmd),
        .host_ack(host_ack), .host_rdata(host_rdata),
        .bkpt_hit(bkpt_hit), .video_load(video_load), .pixel(pixel)
    );

    // ====================
    // clock, 40 ns period
    initial begin
        clk25 = 1'b0;
        forever #20 clk25 = ~clk25;
    end

    // index of the current load, seen before the update lands
    always @(negedge clk25) begin
        if (reset_in)
            load_count <= 0;
        else if (video_load)
            load_count <= load_count + 1;
    end

    // word after a cpu write; a byte op lands on the lane chosen by addr[0]
    function automatic logic [15:0] lane_merge(input logic [15:0] old, input logic byte_op,
                                              input logic [15:0] addr, input logic [15:0] data);
        if (!byte_op)
            return data;
        if (addr[0])
            return {data[7:0], old[7:0]};     // odd address, high byte
        return {old[15:8], data[7:0]};
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp)
        else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    // ====================
    // waits, sampled mid cycle
    task automatic wait_level(input int sel, input logic level, input string what);
        int   cnt;
        logic v;
        cnt = 0;
        v   = ~level;
        while (v !== level && cnt < wait_limit) begin
            @(negedge clk25);
            case (sel)
                sel_ack:   v = host_ack;
                sel_reply: v = cpu_reply;
                default:   v = video_load;
            endcase
            cnt++;
        end
        assert (v === level)
        else begin
            $display("timeout: %s did not reach %0b within %0d clocks", what, level, wait_limit);
            err_count++;
        end
    endtask

    // one full four phase host handshake
    task automatic host_xfer(input bk_bus_pkg::host_op_e op, input logic [15:0] addr,
                             input logic [15:0] data, output logic [15:0] rdata);
        @(posedge clk25);
        #2;
        host_cmd.op    = op;
        host_cmd.addr  = addr;
        host_cmd.wdata = data;
        host_req       = 1'b1;
        wait_level(sel_ack, 1'b1, "host_ack");
        rdata = host_rdata;                    // valid while ack is up
        @(posedge clk25);
        #2;
        host_req = 1'b0;
        wait_level(sel_ack, 1'b0, "host_ack release");
    endtask

    task automatic cpu_drive(input logic wt, input logic byte_op, input logic ifetch,
                             input logic [15:0] addr, input logic [15:0] data);
        @(posedge clk25);
        #2;
        cpu_bus.rd      = ~wt;
        cpu_bus.wt      = wt;
        cpu_bus.byte_op = byte_op;
        cpu_bus.ifetch  = ifetch;
        cpu_bus.addr    = addr;
        cpu_bus.wdata   = data;
    endtask

    task automatic cpu_finish(output logic [15:0] rdata);
        wait_level(sel_reply, 1'b1, "cpu_reply");
        rdata = cpu_rdata;
        @(posedge clk25);
        #2;
        cpu_bus = '0;                          // rd/wt drop together
        wait_level(sel_reply, 1'b0, "cpu_reply release");
    endtask

    // fetch held by the breakpoint, then released by the host
    task automatic stalled_fetch(input string name, input logic [15:0] addr,
                                 input logic [15:0] exp);
        logic        hit_seen;
        logic        reply_seen;
        logic [15:0] unused;
        logic [15:0] got;
        hit_seen   = 1'b0;
        reply_seen = 1'b0;
        cpu_drive(1'b0, 1'b0, 1'b1, addr, 16'h0000);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk25);
            hit_seen   = hit_seen | bkpt_hit;
            reply_seen = reply_seen | cpu_reply;
        end
        assert (hit_seen && !reply_seen)
        else begin
            $display("%s: fetch at the breakpoint was not held (hit %0b, reply %0b)",
                     name, hit_seen, reply_seen);
            err_count++;
        end
        host_xfer(bk_bus_pkg::host_clear_bkpt, 16'h0000, 16'h0000, unused);
        cpu_finish(got);
        check_value(name, exp, got);
        assert (!bkpt_hit)
        else begin
            $display("%s: stall still shown after the breakpoint was cleared", name);
            err_count++;
        end
    endtask

    // ====================
    // pixel stream check
    task automatic scan_video(input string name, input int loads);
        int          idx;
        logic [15:0] bits;
        logic [15:0] exp;
        for (int n = 0; n < loads; n++) begin
            wait_level(sel_load, 1'b1, "video_load");
            idx  = load_count;                                 // load k fetches offset k
            exp  = model_mem[(video_base + idx % video_words) % mem_words];
            bits = 16'h0000;
            for (int b = 0; b < 16; b++) begin
                if (b > 0)
                    @(negedge clk25);
                bits = {bits[14:0], pixel};                    // msb first
            end
            check_value(name, exp, bits);
        end
    endtask

    task automatic run_vector(input string name, input string kind, input string op,
                              input logic [15:0] addr, input logic [15:0] data,
                              input logic [15:0] expv);
        logic [15:0] got;
        logic [15:0] got_c;
        logic [15:0] exp_model;
        int          word;
        word = {1'b0, addr[15:1]};            // word behind a cpu byte address
        if (kind == "host" && op == "wr") begin
            host_xfer(bk_bus_pkg::host_write, addr, data, got);
            model_mem[addr % mem_words] = data;
        end else if (kind == "host" && op == "rd") begin
            host_xfer(bk_bus_pkg::host_read, addr, 16'h0000, got);
            check_value(name, expv, got);
        end else if (kind == "host" && op == "sb") begin
            host_xfer(bk_bus_pkg::host_set_bkpt, addr, 16'h0000, got);
        end else if (kind == "host" && op == "cb") begin
            host_xfer(bk_bus_pkg::host_clear_bkpt, addr, 16'h0000, got);
        end else if (kind == "cpu" && (op == "wr" || op == "wb")) begin
            exp_model = lane_merge(model_mem[word % mem_words], op == "wb", addr, data);
            assert (exp_model === expv)
            else begin
                $display("%s: vector expects %h but the lane rule gives %h",
                         name, expv, exp_model);
                err_count++;
            end
            cpu_drive(1'b1, op == "wb", 1'b0, addr, data);
            cpu_finish(got);
            model_mem[word % mem_words] = exp_model;
            host_xfer(bk_bus_pkg::host_read, 16'(word), 16'h0000, got);   // read back
            check_value(name, expv, got);
        end else if (kind == "cpu" && op == "rd") begin
            cpu_drive(1'b0, 1'b0, 1'b0, addr, 16'h0000);
            cpu_finish(got);
            check_value(name, expv, got);
        end else if (kind == "cpu" && op == "ifbk") begin
            stalled_fetch(name, addr, expv);
        end else if (kind == "mix" && op == "wr") begin
            fork                                              // both pending at once
                host_xfer(bk_bus_pkg::host_write, addr, data, got);
                begin
                    cpu_drive(1'b1, 1'b0, 1'b0, (addr + 16'd1) << 1, ~data);
                    cpu_finish(got_c);
                end
            join
            model_mem[addr % mem_words]       = data;
            model_mem[(addr + 1) % mem_words] = ~data;        // next word from the cpu
        end else if (kind == "mix" && op == "rd") begin
            fork
                host_xfer(bk_bus_pkg::host_read, addr, 16'h0000, got);
                begin
                    cpu_drive(1'b0, 1'b0, 1'b0, addr << 1, 16'h0000);
                    cpu_finish(got_c);
                end
            join
            check_value({name, "_host"}, expv, got);
            check_value({name, "_cpu"}, expv, got_c);
        end else if (kind == "video" && op == "chk") begin
            scan_video(name, addr);                           // addr holds the load count
        end else begin
            $display("%s: unknown operation %s %s", name, kind, op);
            err_count++;
        end
    endtask

    // ====================
    // main sequence
    initial begin
        string       name;
        string       kind;
        string       op;
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] expv;
        int          fd;
        int          n;
        int          c;
        int          seed_val;
        int          errs_before;
        int          tests_run;
        int          tests_failed;

        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_in     = 1'b1;
        host_req     = 1'b0;
        host_cmd     = '0;
        cpu_bus      = '0;
        seed_val     = $urandom(32'hc358a00d);               // idle gaps repeat run to run
        for (int i = 0; i < mem_words; i++)
            model_mem[i] = 16'h0000;                          // ram starts cleared
        repeat (3) @(posedge clk25);
        #2;
        reset_in = 1'b0;

        fd = $fopen("bench/bk_input_vectors.txt", "r");
        assert (fd != 0)
        else begin
            $display("cannot open the vector file bench/bk_input_vectors.txt");
            err_count++;
        end

        while (fd != 0 && !$feof(fd)) begin
            n = $fscanf(fd, "%s", name);
            if (n != 1)
                break;
            if (name == "#") begin                            // comment line
                c = $fgetc(fd);
                while (c != 10 && c != -1)
                    c = $fgetc(fd);
                continue;
            end
            n = $fscanf(fd, "%s %s %h %h %h", kind, op, addr, data, expv);
            errs_before = err_count;
            repeat ($urandom % 4) @(posedge clk25);           // 0..3 idle clocks
            assert (n == 5)
            else begin
                $display("%s: vector line has %0d of 5 fields after the name", name, n);
                err_count++;
            end
            if (n == 5)
                run_vector(name, kind, op, addr, data, expv);
            tests_run++;
            if (err_count == errs_before) begin
                $display("test %s: ok", name);
            end else begin
                tests_failed++;
                $display("test %s: failed", name);
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
        if (err_count == 0 && tests_run > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/bk_input_vectors.txt
# columns: name kind op addr data expected (hex); host addr is a word, cpu addr a byte
# video chk: addr is the number of loads to check; words come from the host fills
hw_basic    host  wr   0010 a5c3 0000
hr_basic    host  rd   0010 0000 a5c3
cpu_word_wr cpu   wr   0040 1234 1234
host_seed   host  wr   0030 beef 0000
cpu_word_rd cpu   rd   0060 0000 beef
byte_hi     cpu   wb   0041 0077 7734
byte_lo     cpu   wb   0040 559a 779a
bk_arm      host  sb   0060 0000 0000
bk_fetch    cpu   ifbk 0060 0000 beef
bk_rearm    host  sb   0060 0000 0000
bk_plain_rd cpu   rd   0060 0000 beef
bk_disarm   host  cb   0000 0000 0000
mix_wr      mix   wr   0050 c0de 0000
mix_chk     host  rd   0051 0000 3f21
mix_rd      mix   rd   0050 0000 c0de
vid_w0      host  wr   0800 8001 0000
vid_w1      host  wr   0801 f00f 0000
vid_w2      host  wr   0802 0ff0 0000
vid_w3      host  wr   0803 5a3c 0000
vid_scan    video chk  000a 0000 0000

//--- sim.f
logic/bk_bus_pkg.sv
logic/slot_timer.sv
logic/host_port.sv
logic/bus_sequencer.sv
logic/video_ram.sv
logic/pixel_shifter.sv
logic/bk_membus_top.sv
bench/tb_bk_membus.sv
